//--- bbc_pkg.sv
package bbc_pkg;

	// Phase counter width, 32 MHz down to 1 MHz
	localparam int div_bits = 5;

	localparam int addr_w = 16;
	localparam int vid_addr_w = 15;

	// Pages at the top of the memory map
	localparam logic [7:0] fred_page = 8'hfc;
	localparam logic [7:0] jim_page = 8'hfd;
	localparam logic [7:0] sheila_page = 8'hfe;

	// ACIA is not fitted, reads return a fixed status
	localparam logic [7:0] acia_status = 8'h02;

	// High address offsets for scroll modes 0 to 3 (entry 0 is the lowest nibble)
	localparam logic [3:0][3:0] scroll_offs = {4'd11, 4'd6, 4'd12, 4'd8};

	typedef struct packed {
		logic ram;
		logic rom;
		logic mos;
		logic fred;
		logic jim;
		logic sheila;
	} region_sel_t;

	typedef struct packed {
		logic crtc;
		logic acia;
		logic serproc;
		logic vidproc;
		logic romsel;
		logic sys_via;
		logic user_via;
		logic fddc;
		logic adlc;
		logic adc;
		logic tube;
	} io_sel_t;

	typedef struct packed {
		logic vid;
		logic mhz4;
		logic mhz2;
		logic mhz1;
		logic cpu;
	} clk_en_t;

	// IC32 addressable latch, bit 7 down to bit 0
	typedef struct packed {
		logic shift_lock_led_n;
		logic caps_lock_led_n;
		logic [1:0] disp_addr_offs;
		logic keyb_enable_n;
		logic speech_read_n;
		logic speech_write_n;
		logic sound_enable_n;
	} ic32_t;

endpackage

//--- clocks.sv
`timescale 1ns/1ps

module clocks
	import bbc_pkg::*;
(
	input logic CLK32M_I,
	input logic rst,
	input logic slow_access,
	output clk_en_t en
);

	logic [div_bits-1:0] phase;
	logic mhz2_pulse;
	logic mhz1_pulse;

	// Free running, wraps every 32 cycles
	always_ff @(posedge CLK32M_I)
	begin
		if (rst)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	assign mhz2_pulse = &phase[3:0];
	assign mhz1_pulse = &phase;

	assign en.vid = phase[0];
	assign en.mhz4 = &phase[2:0];
	assign en.mhz2 = mhz2_pulse;
	assign en.mhz1 = mhz1_pulse;

	// Slow peripherals hold the CPU off until the next 1 MHz edge
	assign en.cpu = mhz2_pulse & (~slow_access | mhz1_pulse);

	// Slower enables always land on a faster one
	a_nested_enables: assert property (
		@(posedge CLK32M_I) disable iff (rst)
		(en.mhz1 |-> en.mhz2) and (en.mhz2 |-> en.mhz4)
	);

endmodule

//--- address_decode.sv
`timescale 1ns/1ps

module address_decode
	import bbc_pkg::*;
(
	input logic [addr_w-1:0] cpu_a,
	output region_sel_t region,
	output io_sel_t io,
	output logic slow_access
);

	logic [7:0] page;

	assign page = cpu_a[15:8];

	always_comb
	begin
		region = '0;
		io = '0;

		if (!cpu_a[15])
			region.ram = 1'b1;
		else if (!cpu_a[14])
			region.rom = 1'b1;
		else if (page == fred_page)
			region.fred = 1'b1;
		else if (page == jim_page)
			region.jim = 1'b1;
		else if (page == sheila_page)
			region.sheila = 1'b1;
		else
			region.mos = 1'b1;

		// SHEILA split into 32 byte blocks
		if (page == sheila_page)
		begin
			case (cpu_a[7:5])
				3'd0:
				begin
					if (cpu_a[4])
						io.serproc = 1'b1;
					else if (cpu_a[3])
						io.acia = 1'b1;
					else
						io.crtc = 1'b1;
				end
				3'd1:
				begin
					if (cpu_a[4])
						io.romsel = 1'b1;
					else
						io.vidproc = 1'b1;
				end
				3'd2: io.sys_via = 1'b1;
				3'd3: io.user_via = 1'b1;
				3'd4: io.fddc = 1'b1;
				3'd5: io.adlc = 1'b1;
				3'd6: io.adc = 1'b1;
				default: io.tube = 1'b1;
			endcase
		end
	end

	// Everything on the 1 MHz bus
	assign slow_access = region.fred | region.jim | io.acia | io.serproc |
		io.sys_via | io.user_via | io.adc;

	always_comb
	begin
		a_region_onehot: assert ($isunknown(cpu_a) || $onehot(region));
	end

endmodule

//--- system_latches.sv
`timescale 1ns/1ps

module system_latches
	import bbc_pkg::*;
(
	input logic CLK32M_I,
	input logic rst,
	input logic romsel_sel,
	input logic cpu_we,
	input logic cpu_en,
	input logic [7:0] cpu_do,
	input logic [3:0] sys_via_pb,
	output logic [3:0] romsel,
	output ic32_t ic32
);

	logic romsel_wr;
	logic [7:0] latch_bits;

	// Only a real CPU write cycle to FE30
	assign romsel_wr = romsel_sel & cpu_we & cpu_en;

	always_ff @(posedge CLK32M_I)
	begin
		if (rst)
		begin
			romsel <= '0;
			latch_bits <= '0;
		end
		else
		begin
			if (romsel_wr)
				romsel <= cpu_do[3:0];
			// PB2..0 address the bit, PB3 is the data
			latch_bits[sys_via_pb[2:0]] <= sys_via_pb[3];
		end
	end

	assign ic32 = ic32_t'(latch_bits);

	a_romsel_write_only: assert property (
		@(posedge CLK32M_I) disable iff (rst)
		!$stable(romsel) |-> $past(romsel_wr)
	);

endmodule

//--- display_address.sv
`timescale 1ns/1ps

module display_address
	import bbc_pkg::*;
(
	input logic [13:0] crtc_ma,
	input logic [4:0] crtc_ra,
	input logic [1:0] offs,
	output logic [vid_addr_w-1:0] vid_adr
);

	logic [3:0] high_nibble;

	always_comb
	begin
		// Screen runs past 7FFF, fold it back by the mode offset
		if (crtc_ma[12])
			high_nibble = crtc_ma[11:8] + scroll_offs[offs];
		else
			high_nibble = crtc_ma[11:8];

		if (crtc_ma[13])
		begin
			// Teletext, 1K screen at 3C00 or 7C00
			vid_adr = {high_nibble[3], 4'b1111, crtc_ma[9:0]};
		end
		else
		begin
			// Bitmap modes, eight scan lines per character row
			vid_adr = {high_nibble, crtc_ma[7:0], crtc_ra[2:0]};
		end
	end

endmodule

//--- cpu_bus_glue.sv
`timescale 1ns/1ps

module cpu_bus_glue
	import bbc_pkg::*;
(
	input logic CLK32M_I,
	input logic rst,
	input logic cpu_en,
	input region_sel_t region,
	input io_sel_t io,
	input logic cpu_we,
	input logic [7:0] mem_di,
	input logic [7:0] crtc_do,
	input logic [7:0] sys_via_do,
	input logic [7:0] user_via_do,
	input logic sys_via_irq_n,
	input logic user_via_irq_n,
	output logic [7:0] cpu_di,
	output logic mem_we,
	output logic cpu_irq
);

	logic [7:0] rd_mux;

	// Memory first, then the I/O devices that drive the bus
	always_comb
	begin
		if (region.ram || region.rom || region.mos)
			rd_mux = mem_di;
		else if (io.crtc)
			rd_mux = crtc_do;
		else if (io.acia)
			rd_mux = acia_status;
		else if (io.sys_via)
			rd_mux = sys_via_do;
		else if (io.user_via)
			rd_mux = user_via_do;
		else
			rd_mux = '0;
	end

	// Retard read data by one CPU cycle
	always_ff @(posedge CLK32M_I)
	begin
		if (rst)
			cpu_di <= '0;
		else if (cpu_en)
			cpu_di <= rd_mux;
	end

	assign mem_we = cpu_we & ~rst;
	// Wired-OR open drain IRQ lines
	assign cpu_irq = ~(sys_via_irq_n & user_via_irq_n);

endmodule

//--- bbc_glue.sv
`timescale 1ns/1ps

module bbc_glue
	import bbc_pkg::*;
(
	input logic CLK32M_I,
	input logic rst,
	input logic [addr_w-1:0] cpu_a,
	input logic [7:0] cpu_do,
	input logic cpu_we,
	input logic [7:0] mem_di,
	input logic [7:0] crtc_do,
	input logic [7:0] sys_via_do,
	input logic [7:0] user_via_do,
	input logic [3:0] sys_via_pb,
	input logic sys_via_irq_n,
	input logic user_via_irq_n,
	input logic [13:0] crtc_ma,
	input logic [4:0] crtc_ra,
	output clk_en_t en,
	output region_sel_t region,
	output io_sel_t io,
	output logic [3:0] romsel,
	output ic32_t ic32,
	output logic [addr_w-1:0] mem_adr,
	output logic [7:0] mem_do,
	output logic mem_we,
	output logic [7:0] cpu_di,
	output logic cpu_irq,
	output logic [vid_addr_w-1:0] vid_adr
);

	logic slow_access;

	clocks clocks0 (
		.CLK32M_I(CLK32M_I),
		.rst(rst),
		.slow_access(slow_access),
		.en(en)
	);

	address_decode decode0 (
		.cpu_a(cpu_a),
		.region(region),
		.io(io),
		.slow_access(slow_access)
	);

	system_latches latches0 (
		.CLK32M_I(CLK32M_I),
		.rst(rst),
		.romsel_sel(io.romsel),
		.cpu_we(cpu_we),
		.cpu_en(en.cpu),
		.cpu_do(cpu_do),
		.sys_via_pb(sys_via_pb),
		.romsel(romsel),
		.ic32(ic32)
	);

	display_address disp0 (
		.crtc_ma(crtc_ma),
		.crtc_ra(crtc_ra),
		.offs(ic32.disp_addr_offs),
		.vid_adr(vid_adr)
	);

	cpu_bus_glue bus0 (
		.CLK32M_I(CLK32M_I),
		.rst(rst),
		.cpu_en(en.cpu),
		.region(region),
		.io(io),
		.cpu_we(cpu_we),
		.mem_di(mem_di),
		.crtc_do(crtc_do),
		.sys_via_do(sys_via_do),
		.user_via_do(user_via_do),
		.sys_via_irq_n(sys_via_irq_n),
		.user_via_irq_n(user_via_irq_n),
		.cpu_di(cpu_di),
		.mem_we(mem_we),
		.cpu_irq(cpu_irq)
	);

	// CPU bus straight through to the memory controller
	assign mem_adr = cpu_a;
	assign mem_do = cpu_do;

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
	output logic CLK32M_I,
	output logic rst
);

	// 20 ns period
	initial
	begin
		CLK32M_I = 1'b0;
		forever #10 CLK32M_I = ~CLK32M_I;
	end

	// Reset held for 10 cycles, released just after an edge
	initial
	begin
		rst = 1'b1;
		repeat (10) @(posedge CLK32M_I);
		#2 rst = 1'b0;
	end

endmodule

//--- bbc_glue_tb.sv
`timescale 1ns/1ps

module bbc_glue_tb
	import bbc_pkg::*;
;

	localparam int hold_blocks = 64;
	localparam int block_cycles = 32;
	localparam int random_cycles = 512;
	// Hold blocks plus one block of ROM bank writes
	localparam int total_cycles = 10 + (hold_blocks + 1) * block_cycles + random_cycles;
	localparam int watchdog_ns = (total_cycles + 200) * 20;

	// Edges of every region and SHEILA device
	localparam logic [15:0] edge_addrs [0:33] = '{
		16'h0000, 16'h7fff, 16'h8000, 16'hbfff, 16'hc000, 16'hfbff, 16'hfc00, 16'hfcff,
		16'hfd00, 16'hfdff, 16'hfe00, 16'hfe07, 16'hfe08, 16'hfe0f, 16'hfe10, 16'hfe1f,
		16'hfe20, 16'hfe2f, 16'hfe30, 16'hfe3f, 16'hfe40, 16'hfe5f, 16'hfe60, 16'hfe7f,
		16'hfe80, 16'hfe9f, 16'hfea0, 16'hfebf, 16'hfec0, 16'hfedf, 16'hfee0, 16'hfeff
		, 16'hff00, 16'hffff
	};

	logic CLK32M_I, rst;
	logic [15:0] cpu_a;
	logic [7:0] cpu_do, mem_di, crtc_do, sys_via_do, user_via_do;
	logic cpu_we, sys_via_irq_n, user_via_irq_n;
	logic [3:0] sys_via_pb;
	logic [13:0] crtc_ma;
	logic [4:0] crtc_ra;

	clk_en_t en;
	region_sel_t region;
	io_sel_t io;
	ic32_t ic32;
	logic [3:0] romsel;
	logic [15:0] mem_adr;
	logic [7:0] mem_do, cpu_di;
	logic mem_we, cpu_irq;
	logic [14:0] vid_adr;

	// Reference model state
	logic [31:0] lfsr = 32'h259c_0022;
	logic reset_seen = 1'b0;
	logic [4:0] ref_phase;
	logic [3:0] ref_romsel;
	logic [7:0] ref_latch;
	logic [7:0] ref_di;
	clk_en_t exp_en;
	region_sel_t exp_region;
	io_sel_t exp_io;
	logic exp_slow;
	logic [7:0] exp_rd;
	logic [14:0] exp_vid;

	tb_clock clk0 (.CLK32M_I(CLK32M_I), .rst(rst));

	bbc_glue dut0 (.*);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, exp);
		stop_run("signal mismatch");
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	function automatic region_sel_t region_for_addr(input logic [15:0] a);
		region_sel_t r;
		r = '0;
		if (a <= 16'h7fff)
			r.ram = 1'b1;
		else if (a <= 16'hbfff)
			r.rom = 1'b1;
		else if (a >= 16'hfc00 && a <= 16'hfcff)
			r.fred = 1'b1;
		else if (a >= 16'hfd00 && a <= 16'hfdff)
			r.jim = 1'b1;
		else if (a >= 16'hfe00 && a <= 16'hfeff)
			r.sheila = 1'b1;
		else
			r.mos = 1'b1;
		return r;
	endfunction

	function automatic io_sel_t sheila_select(input logic [15:0] a);
		io_sel_t s;
		logic [7:0] off;
		s = '0;
		off = a[7:0];
		if (a[15:8] == 8'hfe)
		begin
			if (off < 8'h08) s.crtc = 1'b1;
			else if (off < 8'h10) s.acia = 1'b1;
			else if (off < 8'h20) s.serproc = 1'b1;
			else if (off < 8'h30) s.vidproc = 1'b1;
			else if (off < 8'h40) s.romsel = 1'b1;
			else if (off < 8'h60) s.sys_via = 1'b1;
			else if (off < 8'h80) s.user_via = 1'b1;
			else if (off < 8'ha0) s.fddc = 1'b1;
			else if (off < 8'hc0) s.adlc = 1'b1;
			else if (off < 8'he0) s.adc = 1'b1;
			else s.tube = 1'b1;
		end
		return s;
	endfunction

	function automatic logic [14:0] screen_addr(input logic [13:0] ma, input logic [4:0] ra,
		input logic [1:0] offs);
		logic [3:0] add;
		logic [3:0] nib;
		case (offs)
			2'd0: add = 4'd8;
			2'd1: add = 4'd12;
			2'd2: add = 4'd6;
			default: add = 4'd11;
		endcase
		nib = ma[12] ? ma[11:8] + add : ma[11:8];
		if (ma[13])
			return {nib[3], 4'hf, ma[9:0]};
		return {nib, ma[7:0], ra[2:0]};
	endfunction

	always_comb
	begin
		exp_region = region_for_addr(cpu_a);
		exp_io = sheila_select(cpu_a);
		exp_slow = exp_region.fred | exp_region.jim | exp_io.acia | exp_io.serproc |
			exp_io.sys_via | exp_io.user_via | exp_io.adc;
		exp_en.vid = ref_phase[0];
		exp_en.mhz4 = (ref_phase[2:0] == 3'd7);
		exp_en.mhz2 = (ref_phase[3:0] == 4'd15);
		exp_en.mhz1 = (ref_phase == 5'd31);
		exp_en.cpu = exp_en.mhz2 && (!exp_slow || exp_en.mhz1);
		// Read source priority
		if (exp_region.ram || exp_region.rom || exp_region.mos)
			exp_rd = mem_di;
		else if (exp_io.crtc)
			exp_rd = crtc_do;
		else if (exp_io.acia)
			exp_rd = 8'h02;
		else if (exp_io.sys_via)
			exp_rd = sys_via_do;
		else if (exp_io.user_via)
			exp_rd = user_via_do;
		else
			exp_rd = 8'h00;
		exp_vid = screen_addr(crtc_ma, crtc_ra, ref_latch[5:4]);
	end

	always @(posedge CLK32M_I)
		reset_seen <= 1'b1;

	always_ff @(posedge CLK32M_I)
	begin
		if (rst)
		begin
			ref_phase <= 5'd0;
			ref_romsel <= 4'd0;
			ref_latch <= 8'd0;
			ref_di <= 8'd0;
		end
		else
		begin
			ref_phase <= ref_phase + 5'd1;
			if (exp_io.romsel && cpu_we && exp_en.cpu)
				ref_romsel <= cpu_do[3:0];
			ref_latch[sys_via_pb[2:0]] <= sys_via_pb[3];
			if (exp_en.cpu)
				ref_di <= exp_rd;
		end
	end

	a_en_reset: assert property (@(posedge CLK32M_I) (rst && reset_seen) |-> (en == '0))
		else report_mismatch("en", 32'($sampled(en)), 32'd0);
	a_en: assert property (@(posedge CLK32M_I) disable iff (rst) en == exp_en)
		else report_mismatch("en", 32'($sampled(en)), 32'($sampled(exp_en)));
	a_region: assert property (@(posedge CLK32M_I) disable iff (rst) region == exp_region)
		else report_mismatch("region", 32'($sampled(region)), 32'($sampled(exp_region)));
	a_io: assert property (@(posedge CLK32M_I) disable iff (rst) io == exp_io)
		else report_mismatch("io", 32'($sampled(io)), 32'($sampled(exp_io)));
	a_romsel: assert property (@(posedge CLK32M_I) disable iff (rst) romsel == ref_romsel)
		else report_mismatch("romsel", 32'($sampled(romsel)), 32'($sampled(ref_romsel)));
	a_ic32: assert property (@(posedge CLK32M_I) disable iff (rst) ic32 == ref_latch)
		else report_mismatch("ic32", 32'($sampled(ic32)), 32'($sampled(ref_latch)));
	a_vid: assert property (@(posedge CLK32M_I) disable iff (rst) vid_adr == exp_vid)
		else report_mismatch("vid_adr", 32'($sampled(vid_adr)), 32'($sampled(exp_vid)));
	a_cpu_di: assert property (@(posedge CLK32M_I) disable iff (rst) cpu_di == ref_di)
		else report_mismatch("cpu_di", 32'($sampled(cpu_di)), 32'($sampled(ref_di)));
	a_mem_we: assert property (@(posedge CLK32M_I) mem_we == (cpu_we && !rst))
		else report_mismatch("mem_we", 32'($sampled(mem_we)), 32'($sampled(cpu_we && !rst)));
	a_irq: assert property (@(posedge CLK32M_I)
		cpu_irq == (!sys_via_irq_n || !user_via_irq_n))
		else report_mismatch("cpu_irq", 32'($sampled(cpu_irq)),
			32'($sampled(!sys_via_irq_n || !user_via_irq_n)));
	a_mem_bus: assert property (@(posedge CLK32M_I) {mem_adr, mem_do} == {cpu_a, cpu_do})
		else report_mismatch("mem_adr/mem_do", 32'($sampled({mem_adr, mem_do})),
			32'($sampled({cpu_a, cpu_do})));

	// One cycle of random peripheral activity at a given CPU address
	task automatic drive_cycle(input logic [15:0] addr);
		logic [31:0] b;
		@(posedge CLK32M_I);
		#2;
		cpu_a = addr;
		take_bits(8, b);
		cpu_do = b[7:0];
		take_bits(1, b);
		cpu_we = b[0];
		take_bits(32, b);
		{mem_di, crtc_do, sys_via_do, user_via_do} = b;
		take_bits(4, b);
		sys_via_pb = b[3:0];
		take_bits(2, b);
		{sys_via_irq_n, user_via_irq_n} = b[1:0];
		take_bits(19, b);
		{crtc_ma, crtc_ra} = b[18:0];
	endtask

	initial
	begin
		#(watchdog_ns);
		stop_run("Watchdog expired before the stimulus finished");
	end

	initial
	begin
		logic [31:0] b;
		logic [15:0] addr;
		cpu_a = '0;
		cpu_do = '0;
		// Write request during reset must not reach memory
		cpu_we = 1'b1;
		mem_di = '0;
		crtc_do = '0;
		sys_via_do = '0;
		user_via_do = '0;
		sys_via_pb = '0;
		sys_via_irq_n = 1'b1;
		user_via_irq_n = 1'b1;
		crtc_ma = '0;
		crtc_ra = '0;
		@(negedge rst);

		// Address held for a whole 1 MHz period, so every phase sees it
		for (int blk = 0; blk < hold_blocks; blk++)
		begin
			take_bits(16, b);
			addr = (blk < 34) ? edge_addrs[blk] : b[15:0];
			for (int c = 0; c < block_cycles; c++)
				drive_cycle(addr);
		end

		// ROM bank writes on every cycle, only the CPU enable loads one
		for (int c = 0; c < block_cycles; c++)
		begin
			drive_cycle(16'hfe30);
			cpu_we = 1'b1;
		end

		for (int c = 0; c < random_cycles; c++)
		begin
			take_bits(16, b);
			drive_cycle(b[15:0]);
		end

		repeat (2) @(posedge CLK32M_I);
		$display("Verification passed");
		$finish;
	end

endmodule

//--- vlog.f
bbc_pkg.sv
clocks.sv
address_decode.sv
system_latches.sv
display_address.sv
cpu_bus_glue.sv
bbc_glue.sv
tb_clock.sv
bbc_glue_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= bbc_glue_tb
RTL_TOP ?= bbc_glue
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only bbc_pkg.sv clocks.sv address_decode.sv system_latches.sv \
		display_address.sv cpu_bus_glue.sv bbc_glue.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
